// ==== cache_subsys_pkg.sv ====
// widths fixed for the whole memory path; only the cache index widths are module parameters
`default_nettype none

package cache_subsys_pkg;

    localparam int ADDR_W   = 32;                // byte address
    localparam int WORD_W   = 32;
    localparam int OFFSET_W = 2;                 // word offset within a line
    localparam int STRB_W   = WORD_W / 8;        // one strobe per byte
    localparam int BOFF_W   = $clog2(STRB_W);    // byte offset within a word
    localparam int LINE_W   = WORD_W << OFFSET_W;

endpackage

`default_nettype wire

// ==== icache.sv ====
// read-only direct-mapped cache, one miss in flight, ic_inv_i only honoured while idle
`default_nettype none
`timescale 1ns/1ps

module icache
    import cache_subsys_pkg::*;
#(
    parameter int I_INDEX_W = 4
) (
    input  wire                clk,
    input  wire                rstn,
    input  wire                if_req_i,
    input  wire [ADDR_W-1:0]   if_addr_i,
    input  wire                ic_inv_i,
    input  wire                fill_done_i,
    input  wire [LINE_W-1:0]   fill_line_i,
    output logic [WORD_W-1:0]  if_data_o,
    output logic               if_valid_o,
    output logic               if_busy_o,
    output logic               fill_req_o,
    output logic [ADDR_W-1:0]  fill_addr_o
);

    localparam int TAG_W = ADDR_W - I_INDEX_W - OFFSET_W - BOFF_W;
    localparam int SETS  = 1 << I_INDEX_W;

    localparam logic S_IDLE   = 1'b0;
    localparam logic S_REFILL = 1'b1;

    logic                 state_q;
    logic [SETS-1:0]      valid_q;
    logic [TAG_W-1:0]     tag_q [SETS];
    logic [LINE_W-1:0]    line_q [SETS];
    logic [ADDR_W-1:0]    miss_addr_q;

    logic [I_INDEX_W-1:0] req_idx, miss_idx;
    logic [TAG_W-1:0]     req_tag, miss_tag;
    logic [OFFSET_W-1:0]  req_woff, miss_woff;
    logic                 hit;

    assign req_idx   = if_addr_i[BOFF_W+OFFSET_W +: I_INDEX_W];
    assign req_tag   = if_addr_i[ADDR_W-1 -: TAG_W];
    assign req_woff  = if_addr_i[BOFF_W +: OFFSET_W];
    assign miss_idx  = miss_addr_q[BOFF_W+OFFSET_W +: I_INDEX_W];
    assign miss_tag  = miss_addr_q[ADDR_W-1 -: TAG_W];
    assign miss_woff = miss_addr_q[BOFF_W +: OFFSET_W];

    assign hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    assign if_busy_o   = (state_q == S_REFILL);
    assign fill_req_o  = if_busy_o;                // held until the arbiter answers
    assign fill_addr_o = {miss_addr_q[ADDR_W-1:BOFF_W+OFFSET_W], {(BOFF_W+OFFSET_W){1'b0}}};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q    <= S_IDLE;
            valid_q    <= '0;
            if_valid_o <= 1'b0;
        end else begin
            if_valid_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (ic_inv_i) begin
                        valid_q <= '0;             // flush all lines
                    end
                    if (if_req_i) begin
                        if (hit) begin
                            if_valid_o <= 1'b1;
                        end else begin
                            state_q <= S_REFILL;
                        end
                    end
                end
                S_REFILL: begin
                    if (fill_done_i) begin
                        valid_q[miss_idx] <= 1'b1;
                        if_valid_o        <= 1'b1;
                        state_q           <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && if_req_i) begin
            miss_addr_q <= if_addr_i;
            if_data_o   <= line_q[req_idx][req_woff*WORD_W +: WORD_W];
        end
        if (state_q == S_REFILL && fill_done_i) begin
            tag_q[miss_idx]  <= miss_tag;
            line_q[miss_idx] <= fill_line_i;
            if_data_o        <= fill_line_i[miss_woff*WORD_W +: WORD_W]; // critical word
        end
    end

endmodule

`default_nettype wire

// ==== dcache.sv ====
// write-through, no allocate on write miss; every store goes to memory as one strobed word
`default_nettype none
`timescale 1ns/1ps

module dcache
    import cache_subsys_pkg::*;
#(
    parameter int D_INDEX_W = 4
) (
    input  wire                clk,
    input  wire                rstn,
    input  wire                d_req_i,
    input  wire                d_we_i,
    input  wire [ADDR_W-1:0]   d_addr_i,
    input  wire [WORD_W-1:0]   d_wdata_i,
    input  wire [STRB_W-1:0]   d_wstrb_i,
    input  wire                mem_done_i,
    input  wire [LINE_W-1:0]   fill_line_i,
    output logic [WORD_W-1:0]  d_rdata_o,
    output logic               d_done_o,
    output logic               d_busy_o,
    output logic               mem_req_o,
    output logic               mem_we_o,
    output logic [ADDR_W-1:0]  mem_addr_o,
    output logic [WORD_W-1:0]  mem_wdata_o,
    output logic [STRB_W-1:0]  mem_wstrb_o
);

    localparam int TAG_W = ADDR_W - D_INDEX_W - OFFSET_W - BOFF_W;
    localparam int SETS  = 1 << D_INDEX_W;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_REFILL = 2'd1;
    localparam logic [1:0] S_STORE  = 2'd2;

    logic [1:0]           state_q;
    logic [SETS-1:0]      valid_q;
    logic [TAG_W-1:0]     tag_q [SETS];
    logic [LINE_W-1:0]    line_q [SETS];
    logic [ADDR_W-1:0]    req_addr_q;
    logic [WORD_W-1:0]    wdata_q;
    logic [STRB_W-1:0]    wstrb_q;

    logic [D_INDEX_W-1:0] req_idx, pend_idx;
    logic [TAG_W-1:0]     req_tag, pend_tag;
    logic [OFFSET_W-1:0]  req_woff, pend_woff;
    logic                 hit;

    // byte merge of a store into a cached word
    function automatic logic [WORD_W-1:0] merge_word(input logic [WORD_W-1:0] old_w,
                                                     input logic [WORD_W-1:0] new_w,
                                                     input logic [STRB_W-1:0] strb);
        logic [WORD_W-1:0] res;
        res = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign req_idx   = d_addr_i[BOFF_W+OFFSET_W +: D_INDEX_W];
    assign req_tag   = d_addr_i[ADDR_W-1 -: TAG_W];
    assign req_woff  = d_addr_i[BOFF_W +: OFFSET_W];
    assign pend_idx  = req_addr_q[BOFF_W+OFFSET_W +: D_INDEX_W];
    assign pend_tag  = req_addr_q[ADDR_W-1 -: TAG_W];
    assign pend_woff = req_addr_q[BOFF_W +: OFFSET_W];

    assign hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    assign d_busy_o    = (state_q != S_IDLE);
    assign mem_req_o   = d_busy_o;
    assign mem_we_o    = (state_q == S_STORE);
    assign mem_wdata_o = wdata_q;
    assign mem_wstrb_o = mem_we_o ? wstrb_q : '0;  // loads carry no strobes
    assign mem_addr_o  = mem_we_o ? {req_addr_q[ADDR_W-1:BOFF_W], {BOFF_W{1'b0}}}
                                  : {req_addr_q[ADDR_W-1:BOFF_W+OFFSET_W],
                                     {(BOFF_W+OFFSET_W){1'b0}}};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q  <= S_IDLE;
            valid_q  <= '0;
            d_done_o <= 1'b0;
        end else begin
            d_done_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (d_req_i) begin
                        if (d_we_i) begin
                            state_q <= S_STORE;
                        end else if (hit) begin
                            d_done_o <= 1'b1;
                        end else begin
                            state_q <= S_REFILL;
                        end
                    end
                end
                S_REFILL: begin
                    if (mem_done_i) begin
                        valid_q[pend_idx] <= 1'b1;
                        d_done_o          <= 1'b1;
                        state_q           <= S_IDLE;
                    end
                end
                S_STORE: begin
                    if (mem_done_i) begin
                        d_done_o <= 1'b1;
                        state_q  <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && d_req_i) begin
            req_addr_q <= d_addr_i;
            wdata_q    <= d_wdata_i;
            wstrb_q    <= d_wstrb_i;
            if (!d_we_i) begin
                d_rdata_o <= line_q[req_idx][req_woff*WORD_W +: WORD_W];
            end else if (hit) begin
                line_q[req_idx][req_woff*WORD_W +: WORD_W] <=
                    merge_word(line_q[req_idx][req_woff*WORD_W +: WORD_W], d_wdata_i, d_wstrb_i);
            end
        end
        if (state_q == S_REFILL && mem_done_i) begin
            tag_q[pend_idx]  <= pend_tag;
            line_q[pend_idx] <= fill_line_i;
            d_rdata_o        <= fill_line_i[pend_woff*WORD_W +: WORD_W];
        end
    end

endmodule

`default_nettype wire

// ==== refill_arbiter.sv ====
// dcache wins when idle; grant is held until mem_done_i, requests must stay up while waiting
`default_nettype none
`timescale 1ns/1ps

module refill_arbiter
    import cache_subsys_pkg::*;
(
    input  wire                clk,
    input  wire                rstn,
    input  wire                ic_req_i,
    input  wire [ADDR_W-1:0]   ic_addr_i,
    input  wire                dc_req_i,
    input  wire                dc_we_i,
    input  wire [ADDR_W-1:0]   dc_addr_i,
    input  wire [WORD_W-1:0]   dc_wdata_i,
    input  wire [STRB_W-1:0]   dc_wstrb_i,
    input  wire [LINE_W-1:0]   mem_rline_i,
    input  wire                mem_done_i,
    output logic               ic_done_o,
    output logic               dc_done_o,
    output logic [LINE_W-1:0]  line_o,
    output logic               mem_req_o,
    output logic [ADDR_W-1:0]  mem_addr_o,
    output logic               mem_we_o,
    output logic [WORD_W-1:0]  mem_wdata_o,
    output logic [STRB_W-1:0]  mem_wstrb_o
);

    localparam logic [1:0] G_IDLE = 2'd0;
    localparam logic [1:0] G_IC   = 2'd1;
    localparam logic [1:0] G_DC   = 2'd2;

    logic [1:0] grant_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            grant_q <= G_IDLE;
        end else if (grant_q == G_IDLE) begin
            if (dc_req_i) begin
                grant_q <= G_DC;                   // data side first
            end else if (ic_req_i) begin
                grant_q <= G_IC;
            end
        end else if (mem_done_i) begin
            grant_q <= G_IDLE;
        end
    end

    assign mem_req_o = (grant_q != G_IDLE);

    always_comb begin
        mem_addr_o  = ic_addr_i;                   // icache fetch is a plain line read
        mem_we_o    = 1'b0;
        mem_wdata_o = '0;
        mem_wstrb_o = '0;
        if (grant_q == G_DC) begin
            mem_addr_o  = dc_addr_i;
            mem_we_o    = dc_we_i;
            mem_wdata_o = dc_wdata_i;
            mem_wstrb_o = dc_wstrb_i;
        end
    end

    assign ic_done_o = mem_done_i && (grant_q == G_IC);
    assign dc_done_o = mem_done_i && (grant_q == G_DC);
    assign line_o    = mem_rline_i;                // only the owner sees a done

endmodule

`default_nettype wire

// ==== cache_subsys_top.sv ====
// icache and dcache share one memory port; memory must hold mem_rline_i valid in the done cycle
`default_nettype none
`timescale 1ns/1ps

module cache_subsys_top
    import cache_subsys_pkg::*;
#(
    parameter int I_INDEX_W = 4,
    parameter int D_INDEX_W = 4
) (
    input  wire                clk,
    input  wire                rstn,
    input  wire                if_req_i,
    input  wire [ADDR_W-1:0]   if_addr_i,
    input  wire                ic_inv_i,
    input  wire                d_req_i,
    input  wire                d_we_i,
    input  wire [ADDR_W-1:0]   d_addr_i,
    input  wire [WORD_W-1:0]   d_wdata_i,
    input  wire [STRB_W-1:0]   d_wstrb_i,
    input  wire [LINE_W-1:0]   mem_rline_i,
    input  wire                mem_done_i,
    output logic [WORD_W-1:0]  if_data_o,
    output logic               if_valid_o,
    output logic               if_busy_o,
    output logic [WORD_W-1:0]  d_rdata_o,
    output logic               d_done_o,
    output logic               d_busy_o,
    output logic               mem_req_o,
    output logic [ADDR_W-1:0]  mem_addr_o,
    output logic               mem_we_o,
    output logic [WORD_W-1:0]  mem_wdata_o,
    output logic [STRB_W-1:0]  mem_wstrb_o
);

    logic              ic_req, ic_done;
    logic [ADDR_W-1:0] ic_addr;
    logic              dc_req, dc_we, dc_done;
    logic [ADDR_W-1:0] dc_addr;
    logic [WORD_W-1:0] dc_wdata;
    logic [STRB_W-1:0] dc_wstrb;
    logic [LINE_W-1:0] line_data;                  // shared refill bus

    icache #(
        .I_INDEX_W (I_INDEX_W)
    ) u_icache (
        .clk         (clk),
        .rstn        (rstn),
        .if_req_i    (if_req_i),
        .if_addr_i   (if_addr_i),
        .ic_inv_i    (ic_inv_i),
        .fill_done_i (ic_done),
        .fill_line_i (line_data),
        .if_data_o   (if_data_o),
        .if_valid_o  (if_valid_o),
        .if_busy_o   (if_busy_o),
        .fill_req_o  (ic_req),
        .fill_addr_o (ic_addr)
    );

    dcache #(
        .D_INDEX_W (D_INDEX_W)
    ) u_dcache (
        .clk         (clk),
        .rstn        (rstn),
        .d_req_i     (d_req_i),
        .d_we_i      (d_we_i),
        .d_addr_i    (d_addr_i),
        .d_wdata_i   (d_wdata_i),
        .d_wstrb_i   (d_wstrb_i),
        .mem_done_i  (dc_done),
        .fill_line_i (line_data),
        .d_rdata_o   (d_rdata_o),
        .d_done_o    (d_done_o),
        .d_busy_o    (d_busy_o),
        .mem_req_o   (dc_req),
        .mem_we_o    (dc_we),
        .mem_addr_o  (dc_addr),
        .mem_wdata_o (dc_wdata),
        .mem_wstrb_o (dc_wstrb)
    );

    refill_arbiter u_arb (
        .clk         (clk),
        .rstn        (rstn),
        .ic_req_i    (ic_req),
        .ic_addr_i   (ic_addr),
        .dc_req_i    (dc_req),
        .dc_we_i     (dc_we),
        .dc_addr_i   (dc_addr),
        .dc_wdata_i  (dc_wdata),
        .dc_wstrb_i  (dc_wstrb),
        .mem_rline_i (mem_rline_i),
        .mem_done_i  (mem_done_i),
        .ic_done_o   (ic_done),
        .dc_done_o   (dc_done),
        .line_o      (line_data),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_we_o    (mem_we_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wstrb_o (mem_wstrb_o)
    );

endmodule

`default_nettype wire

// ==== tb_mem.sv ====
// simulation-only memory: DEPTH words from address 0, fixed delay, one request at a time
`default_nettype none
`timescale 1ns/1ps

module tb_mem
    import cache_subsys_pkg::*;
#(
    parameter int DEPTH = 1024,
    parameter int DELAY = 3
) (
    input  wire                clk,
    input  wire                rstn,
    input  wire                req_i,
    input  wire [ADDR_W-1:0]   addr_i,
    input  wire                we_i,
    input  wire [WORD_W-1:0]   wdata_i,
    input  wire [STRB_W-1:0]   wstrb_i,
    output logic [LINE_W-1:0]  rline_o,
    output logic               done_o
);

    localparam int AW = $clog2(DEPTH);

    logic [WORD_W-1:0] mem [DEPTH];
    logic [AW-1:0]     word_idx;
    logic [AW-1:0]     line_base;
    int                cnt;

    assign word_idx  = addr_i[AW+1:2];
    assign line_base = {addr_i[AW+1:2+OFFSET_W], {OFFSET_W{1'b0}}};

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = (i * 32'h0001_0001) ^ 32'hC35A_9E00;  // same pattern as the shadow
        end
        rline_o = '0;
        done_o  = 1'b0;
    end

    always @(posedge clk) begin
        done_o <= 1'b0;
        if (!rstn) begin
            cnt <= 0;
        end else if (req_i && !done_o) begin      // skip the cycle the grant drops
            if (cnt == DELAY - 1) begin
                cnt    <= 0;
                done_o <= 1'b1;
                if (we_i) begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (wstrb_i[b]) begin
                            mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                        end
                    end
                end else begin
                    for (int w = 0; w < (1 << OFFSET_W); w++) begin
                        rline_o[w*WORD_W +: WORD_W] <= mem[line_base + AW'(w)];
                    end
                end
            end else begin
                cnt <= cnt + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cache_subsys_chk.sv ====
// memory port rules seen from the arbiter; assumes one memory request in flight at a time
`default_nettype none
`timescale 1ns/1ps

module cache_subsys_chk
    import cache_subsys_pkg::*;
(
    input wire                clk,
    input wire                rstn,
    input wire                ic_req_i,
    input wire                dc_req_i,
    input wire                mem_req_i,
    input wire [ADDR_W-1:0]   mem_addr_i,
    input wire                mem_we_i,
    input wire [WORD_W-1:0]   mem_wdata_i,
    input wire [STRB_W-1:0]   mem_wstrb_i,
    input wire                mem_done_i,
    input wire                ic_done_i,
    input wire                dc_done_i
);

    int unsigned fail_count = 0;

    // request held with all fields until done
    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_i && !mem_done_i |=> mem_req_i && $stable(mem_addr_i) && $stable(mem_we_i)
            && $stable(mem_wdata_i) && $stable(mem_wstrb_i))
    else begin
        fail_count++;
        $error("mem_req_o dropped or changed before mem_done_i");
    end

    // each memory done reaches exactly one cache
    a_one_done: assert property (@(posedge clk) disable iff (!rstn)
        mem_done_i |-> (ic_done_i != dc_done_i))
    else begin
        fail_count++;
        $error("mem_done_i not routed to exactly one of ic_done_o and dc_done_o");
    end

    a_done_granted: assert property (@(posedge clk) disable iff (!rstn)
        (!ic_done_i || ic_req_i) && (!dc_done_i || dc_req_i))
    else begin
        fail_count++;
        $error("done pulse to a cache that holds no request");
    end

endmodule

bind refill_arbiter cache_subsys_chk u_chk (
    .clk         (clk),
    .rstn        (rstn),
    .ic_req_i    (ic_req_i),
    .dc_req_i    (dc_req_i),
    .mem_req_i   (mem_req_o),
    .mem_addr_i  (mem_addr_o),
    .mem_we_i    (mem_we_o),
    .mem_wdata_i (mem_wdata_o),
    .mem_wstrb_i (mem_wstrb_o),
    .mem_done_i  (mem_done_i),
    .ic_done_i   (ic_done_o),
    .dc_done_i   (dc_done_o)
);

`default_nettype wire

// ==== tb_cache_subsys.sv ====
// directed tests against a shadow of memory; all addresses stay inside the 4 KB of tb_mem
`default_nettype none
`timescale 1ns/1ps

module tb_cache_subsys
    import cache_subsys_pkg::*;
();

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 50;                 // cycles per wait
    localparam int N_RANDOM  = 200;

    logic              clk;
    logic              rstn;
    logic              if_req;
    logic [ADDR_W-1:0] if_addr;
    logic              ic_inv;
    logic              d_req;
    logic              d_we;
    logic [ADDR_W-1:0] d_addr;
    logic [WORD_W-1:0] d_wdata;
    logic [STRB_W-1:0] d_wstrb;
    logic [LINE_W-1:0] mem_rline;
    logic              mem_done;
    logic [WORD_W-1:0] if_data;
    logic [WORD_W-1:0] d_rdata;
    logic              if_valid, if_busy, d_done, d_busy;
    logic              mem_req, mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [WORD_W-1:0] mem_wdata;
    logic [STRB_W-1:0] mem_wstrb;

    logic [WORD_W-1:0] shadow [MEM_WORDS];
    logic [31:0]       rng;

    cache_subsys_top #(
        .I_INDEX_W (4),
        .D_INDEX_W (4)
    ) u_dut (
        .clk (clk), .rstn (rstn),
        .if_req_i (if_req), .if_addr_i (if_addr), .ic_inv_i (ic_inv),
        .d_req_i (d_req), .d_we_i (d_we), .d_addr_i (d_addr),
        .d_wdata_i (d_wdata), .d_wstrb_i (d_wstrb),
        .mem_rline_i (mem_rline), .mem_done_i (mem_done),
        .if_data_o (if_data), .if_valid_o (if_valid), .if_busy_o (if_busy),
        .d_rdata_o (d_rdata), .d_done_o (d_done), .d_busy_o (d_busy),
        .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_we_o (mem_we),
        .mem_wdata_o (mem_wdata), .mem_wstrb_o (mem_wstrb)
    );

    tb_mem #(
        .DEPTH (MEM_WORDS),
        .DELAY (3)
    ) u_mem (
        .clk (clk), .rstn (rstn), .req_i (mem_req), .addr_i (mem_addr),
        .we_i (mem_we), .wdata_i (mem_wdata), .wstrb_i (mem_wstrb),
        .rline_o (mem_rline), .done_o (mem_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [WORD_W-1:0] fill_word(input logic [31:0] idx);
        return (idx * 32'h0001_0001) ^ 32'hC35A_9E00;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bytes with a strobe come from the new word
    function automatic logic [WORD_W-1:0] apply_strobes(input logic [WORD_W-1:0] old_w,
                                                        input logic [WORD_W-1:0] new_w,
                                                        input logic [STRB_W-1:0] strb);
        logic [WORD_W-1:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout: %s never arrived", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic fetch_check(input string name, input logic [ADDR_W-1:0] addr,
                               input logic [WORD_W-1:0] exp, input bit is_hit);
        int lat;
        logic busy_after_req;
        if_req         = 1'b1;
        if_addr        = addr;
        lat            = 0;
        busy_after_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
            if_req = 1'b0;
            lat++;
            if (lat == 1) begin
                busy_after_req = if_busy;
            end
        end while (!if_valid && lat < TIMEOUT);
        if (!if_valid) begin
            timed_out("if_valid_o after a fetch request");
        end
        check(name, exp, if_data);
        check({name, " busy after request"}, 32'(!is_hit), 32'(busy_after_req));
        check({name, " busy at valid"}, 0, 32'(if_busy));
        if (is_hit) begin
            check({name, " latency"}, 1, lat);
        end
    endtask

    task automatic dc_access(input bit we, input logic [ADDR_W-1:0] addr,
                             input logic [WORD_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                             output logic [WORD_W-1:0] rdata, output int lat);
        logic busy_after_req;
        d_req          = 1'b1;
        d_we           = we;
        d_addr         = addr;
        d_wdata        = wdata;
        d_wstrb        = strb;
        lat            = 0;
        busy_after_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
            d_req = 1'b0;
            lat++;
            if (lat == 1) begin
                busy_after_req = d_busy;
            end
        end while (!d_done && lat < TIMEOUT);
        if (!d_done) begin
            timed_out("d_done_o after a data request");
        end
        // only a one-cycle hit leaves busy low
        check("data busy after request", 32'(lat != 1), 32'(busy_after_req));
        check("data busy at done", 0, 32'(d_busy));
        rdata = d_rdata;
    endtask

    task automatic load_check(input string name, input logic [ADDR_W-1:0] addr,
                              input bit is_hit);
        logic [WORD_W-1:0] data;
        int lat;
        dc_access(1'b0, addr, '0, '0, data, lat);
        check(name, shadow[addr[11:2]], data);
        if (is_hit) begin
            check({name, " latency"}, 1, lat);
        end
    endtask

    task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                              input logic [STRB_W-1:0] strb);
        logic [WORD_W-1:0] rdata;
        int lat;
        dc_access(1'b1, addr, data, strb, rdata, lat);
        shadow[addr[11:2]] = apply_strobes(shadow[addr[11:2]], data, strb);
    endtask

    task automatic fetch_miss_hit();
        fetch_check("fetch miss", 32'h0000_0140, shadow[32'h140 >> 2], 1'b0);
        fetch_check("fetch hit", 32'h0000_014C, shadow[32'h14C >> 2], 1'b1);
    endtask

    task automatic load_miss_hit();
        load_check("load miss", 32'h0000_0208, 1'b0);
        load_check("load hit", 32'h0000_020C, 1'b1);
    endtask

    task automatic store_then_load();
        rng = xorshift32(rng);
        store_word(32'h0000_0204, rng, 4'b0101);
        load_check("store on hit line", 32'h0000_0204, 1'b1);
        rng = xorshift32(rng);
        store_word(32'h0000_03A4, rng, 4'b1010);       // no allocate, next load misses
        load_check("store on missed line", 32'h0000_03A4, 1'b0);
    endtask

    task automatic invalidate_fetch();
        logic [WORD_W-1:0] old_w;
        old_w = shadow[32'h440 >> 2];
        fetch_check("fetch before store", 32'h0000_0440, old_w, 1'b0);
        store_word(32'h0000_0440, 32'h600D_F00D, 4'hF);
        fetch_check("stale fetch", 32'h0000_0440, old_w, 1'b1);
        ic_inv = 1'b1;
        @(posedge clk);
        #1;
        ic_inv = 1'b0;
        fetch_check("fetch after invalidate", 32'h0000_0440, shadow[32'h440 >> 2], 1'b0);
    endtask

    task automatic simultaneous_misses();
        logic [WORD_W-1:0] i_data, d_data;
        bit got_i, got_d;
        int n;
        got_i   = 1'b0;
        got_d   = 1'b0;
        n       = 0;
        if_req  = 1'b1;
        if_addr = 32'h0000_05A8;
        d_req   = 1'b1;
        d_we    = 1'b0;
        d_addr  = 32'h0000_06C4;
        do begin
            @(posedge clk);
            #1;
            if_req = 1'b0;
            d_req  = 1'b0;
            n++;
            if (if_valid) begin
                got_i  = 1'b1;
                i_data = if_data;
            end
            if (d_done) begin
                got_d  = 1'b1;
                d_data = d_rdata;
            end
        end while (!(got_i && got_d) && n < TIMEOUT);
        if (!got_i) begin
            timed_out("if_valid_o during simultaneous misses");
        end else if (!got_d) begin
            timed_out("d_done_o during simultaneous misses");
        end
        check("simultaneous fetch", shadow[32'h5A8 >> 2], i_data);
        check("simultaneous load", shadow[32'h6C4 >> 2], d_data);
    endtask

    task automatic random_mix();
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
        for (int k = 0; k < N_RANDOM; k++) begin
            rng  = xorshift32(rng);
            addr = {20'd0, rng[11:2], 2'b00};
            if (rng[31]) begin
                rng  = xorshift32(rng);
                data = rng;
                rng  = xorshift32(rng);
                store_word(addr, data, rng[3:0]);
            end else begin
                load_check("random load", addr, 1'b0);
            end
        end
    endtask

    initial begin
        rstn    = 1'b0;
        if_req  = 1'b0;
        if_addr = '0;
        ic_inv  = 1'b0;
        d_req   = 1'b0;
        d_we    = 1'b0;
        d_addr  = '0;
        d_wdata = '0;
        d_wstrb = '0;
        rng     = 32'd76852;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fill_word(i);
        end
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        check("reset outputs", 0, 32'({if_valid, d_done, if_busy, d_busy, mem_req}));
        fetch_miss_hit();
        load_miss_hit();
        store_then_load();
        invalidate_fetch();
        simultaneous_misses();
        random_mix();
        if (u_dut.u_arb.u_chk.fail_count != 0) begin
            $display("memory port assertions failed %0d times", u_dut.u_arb.u_chk.fail_count);
            $display("RESULT: FAIL");
            $fatal(1);
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== cache_subsys.f ====
cache_subsys_pkg.sv
icache.sv
dcache.sv
refill_arbiter.sv
cache_subsys_top.sv
tb_mem.sv
cache_subsys_chk.sv
tb_cache_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_cache_subsys -f cache_subsys.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
